// ==== log_icn_top.f ====
log_icn_pkg.sv
request_decoder.sv
memory_bank.sv
response_tree.sv
log_icn_top.sv
tb_log_icn.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it
# Exit status is nonzero on build failure or a failing run

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_log_icn \
    -f log_icn_top.f \
    -o tb_log_icn \
    && ./obj_dir/tb_log_icn \
    || { echo "Simulation did not complete successfully"; exit 1; }

exit 0

// ==== tb_log_icn.sv ====
module tb_log_icn;

    timeunit 1ns;
    timeprecision 100ps;

    import log_icn_pkg::*;

    //////////////////////
    // Run length
    //////////////////////

    localparam int CLK_HALF       = 50;
    // Inputs change this long after the rising edge
    localparam int DRIVE_DELAY    = 10;
    localparam int RESET_CYCLES   = 10;
    localparam int N_ADDR         = 2 ** ADDR_WIDTH;

    localparam int IDLE_CYCLES    = 16;
    localparam int PARTIAL_WRITES = 200;
    localparam int STREAM_CYCLES  = 128;
    localparam int RAW_PAIRS      = 64;
    localparam int RANDOM_CYCLES  = 2000;
    localparam int DRAIN_CYCLES   = 8;
    localparam int MARGIN_CYCLES  = 200;

    // Fill and readback, partial writes plus readback, then the rest
    localparam int TEST_CYCLES    = IDLE_CYCLES + 2 * N_ADDR + PARTIAL_WRITES + N_ADDR
                                  + STREAM_CYCLES + 2 * RAW_PAIRS + RANDOM_CYCLES
                                  + DRAIN_CYCLES;

    // DUT ports
    logic                   clk;
    logic                   reset_i;
    logic                   data_req_i;
    mem_op_e                data_op_i;
    logic [ADDR_WIDTH-1:0]  data_add_i;
    logic [BE_WIDTH-1:0]    data_be_i;
    logic [DATA_WIDTH-1:0]  data_wdata_i;
    logic                   data_r_valid_o;
    logic [DATA_WIDTH-1:0]  data_r_rdata_o;

    // Reference state
    logic [DATA_WIDTH-1:0]  shadow [N_ADDR];
    // Expected responses in issue order, with the cycle each is due
    int                     due_q [$];
    logic [DATA_WIDTH-1:0]  data_q [$];

    logic [31:0]            lcg_state;
    int                     cyc = 0;

    log_icn_top u_dut
    (
        .clk            ( clk            ),
        .reset_i        ( reset_i        ),
        .data_req_i     ( data_req_i     ),
        .data_op_i      ( data_op_i      ),
        .data_add_i     ( data_add_i     ),
        .data_be_i      ( data_be_i      ),
        .data_wdata_i   ( data_wdata_i   ),
        .data_r_valid_o ( data_r_valid_o ),
        .data_r_rdata_o ( data_r_rdata_o )
    );

    //////////////////////
    // Clock and counters
    //////////////////////

    initial
    begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    // Hard limit on the run
    initial
    begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * 2 * CLK_HALF);
        $display("Test failed");
        $fatal(1, "Timeout, the tests did not complete in the expected number of cycles");
    end

    //////////////////////
    // Reference model
    //////////////////////

    // LCG step, constants from Numerical Recipes
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Distinct word per address, every address bit shows
    function automatic logic [DATA_WIDTH-1:0] fill_word(input logic [ADDR_WIDTH-1:0] addr);
        return {addr, ~addr, addr ^ 8'ha5, addr + 8'h3c};
    endfunction

    // Byte lanes with enable set take the new data
    function automatic logic [DATA_WIDTH-1:0] merge_bytes
    (
        input logic [DATA_WIDTH-1:0] old_word,
        input logic [DATA_WIDTH-1:0] wdata,
        input logic [BE_WIDTH-1:0]   be
    );
        logic [DATA_WIDTH-1:0] merged;
        merged = old_word;
        for (int b = 0; b < BE_WIDTH; b++)
        begin
            if (be[b])
            begin
                merged[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    // Read returns the stored word, write returns zero
    function automatic logic [DATA_WIDTH-1:0] reference_response
    (
        input mem_op_e               op,
        input logic [ADDR_WIDTH-1:0] addr
    );
        if (op == OP_WRITE)
        begin
            return '0;
        end
        return shadow[addr];
    endfunction

    //////////////////////
    // Stimulus
    //////////////////////

    task automatic send_request
    (
        input mem_op_e               op,
        input logic [ADDR_WIDTH-1:0] addr,
        input logic [BE_WIDTH-1:0]   be,
        input logic [DATA_WIDTH-1:0] wdata
    );
        @(posedge clk);
        #DRIVE_DELAY;
        data_req_i   = 1'b1;
        data_op_i    = op;
        data_add_i   = addr;
        data_be_i    = be;
        data_wdata_i = wdata;
        // Sampled at the next edge, due RESP_LATENCY cycles after this one
        data_q.push_back(reference_response(op, addr));
        due_q.push_back(cyc + RESP_LATENCY);
        if (op == OP_WRITE)
        begin
            shadow[addr] = merge_bytes(shadow[addr], wdata, be);
        end
    endtask

    task automatic go_idle();
        @(posedge clk);
        #DRIVE_DELAY;
        data_req_i = 1'b0;
    endtask

    task automatic read_all();
        logic [ADDR_WIDTH-1:0] addr;
        addr = '0;
        repeat (N_ADDR)
        begin
            send_request(OP_READ, addr, '0, '0);
            addr = addr + 8'd1;
        end
    endtask

    // Full-word writes over all banks and rows
    task automatic fill_and_read_all();
        logic [ADDR_WIDTH-1:0] addr;
        addr = '0;
        repeat (N_ADDR)
        begin
            send_request(OP_WRITE, addr, '1, fill_word(addr));
            addr = addr + 8'd1;
        end
        read_all();
    endtask

    // Upper LCG bits, the low bits repeat with a short period
    task automatic partial_byte_writes();
        logic [31:0] r;
        repeat (PARTIAL_WRITES)
        begin
            r = next_random();
            send_request(OP_WRITE, r[16 +: ADDR_WIDTH], r[24 +: BE_WIDTH], next_random());
        end
        read_all();
    endtask

    // Consecutive addresses step through the banks, one request per cycle
    task automatic alternating_stream();
        logic [31:0]           r;
        logic [ADDR_WIDTH-1:0] addr;
        addr = '0;
        repeat (STREAM_CYCLES)
        begin
            r = next_random();
            send_request(r[16] ? OP_WRITE : OP_READ, addr, r[24 +: BE_WIDTH], next_random());
            addr = addr + 8'd1;
        end
    endtask

    task automatic read_after_write();
        logic [31:0] r;
        repeat (RAW_PAIRS)
        begin
            r = next_random();
            send_request(OP_WRITE, r[16 +: ADDR_WIDTH], r[24 +: BE_WIDTH], next_random());
            send_request(OP_READ, r[16 +: ADDR_WIDTH], '0, '0);
        end
    endtask

    // Roughly one idle, one read and two writes in four
    task automatic random_mix();
        logic [31:0] r;
        logic [31:0] a;
        repeat (RANDOM_CYCLES)
        begin
            r = next_random();
            a = next_random();
            if (r[1:0] == 2'd0)
            begin
                go_idle();
            end
            else if (r[1:0] == 2'd1)
            begin
                send_request(OP_READ, a[ADDR_WIDTH-1:0], a[ADDR_WIDTH +: BE_WIDTH], r);
            end
            else
            begin
                send_request(OP_WRITE, a[ADDR_WIDTH-1:0], a[ADDR_WIDTH +: BE_WIDTH],
                             next_random());
            end
        end
    endtask

    //////////////////////
    // Checking
    //////////////////////

    task automatic check_value
    (
        input string                 name,
        input logic [DATA_WIDTH-1:0] expected,
        input logic [DATA_WIDTH-1:0] actual
    );
        if (actual !== expected)
        begin
            $display("ERROR %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "Mismatch on %s in cycle %0d", name, cyc);
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk)
    begin
        if (!reset_i)
        begin
            if (due_q.size() != 0 && due_q[0] == cyc)
            begin
                check_value("data_r_valid_o", 32'd1, {31'd0, data_r_valid_o});
                check_value("data_r_rdata_o", data_q[0], data_r_rdata_o);
                void'(due_q.pop_front());
                void'(data_q.pop_front());
            end
            else
            begin
                // Idle cycle, response bus must be quiet
                check_value("data_r_valid_o", 32'd0, {31'd0, data_r_valid_o});
                check_value("data_r_rdata_o", 32'd0, data_r_rdata_o);
            end
        end
    end

    //////////////////////
    // Test sequence
    //////////////////////

    initial
    begin
        reset_i      = 1'b1;
        data_req_i   = 1'b0;
        data_op_i    = OP_READ;
        data_add_i   = '0;
        data_be_i    = '0;
        data_wdata_i = '0;
        lcg_state    = 32'hfc88_727b;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset_i = 1'b0;

        // Quiet bus right after reset
        repeat (IDLE_CYCLES) go_idle();

        fill_and_read_all();
        partial_byte_writes();
        alternating_stream();
        read_after_write();
        random_mix();

        // Let the last responses come out
        repeat (DRAIN_CYCLES) go_idle();
        @(negedge clk);

        if (due_q.size() != 0)
        begin
            $display("Test failed");
            $fatal(1, "%0d expected responses never arrived", due_q.size());
        end
        else
        begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// ==== log_icn_top.sv ====
module log_icn_top
(
    input  logic                                   clk,
    input  logic                                   reset_i,

    // Master request, accepted every cycle
    input  logic                                   data_req_i,
    input  log_icn_pkg::mem_op_e                   data_op_i,
    input  logic [log_icn_pkg::ADDR_WIDTH-1:0]     data_add_i,
    input  logic [log_icn_pkg::BE_WIDTH-1:0]       data_be_i,
    input  logic [log_icn_pkg::DATA_WIDTH-1:0]     data_wdata_i,

    // Master response, fixed latency
    output logic                                   data_r_valid_o,
    output logic [log_icn_pkg::DATA_WIDTH-1:0]     data_r_rdata_o
);

    import log_icn_pkg::*;

    // Request stage to banks
    logic [N_BANK-1:0]                  bank_req;
    mem_op_e                            bank_op;
    logic [ROW_WIDTH-1:0]               bank_row;
    logic [BE_WIDTH-1:0]                bank_be;
    logic [DATA_WIDTH-1:0]              bank_wdata;

    // Banks to response tree
    logic [N_BANK-1:0]                  bank_r_valid;
    logic [N_BANK-1:0][DATA_WIDTH-1:0]  bank_r_rdata;

    //////////////////////
    // Request stage
    //////////////////////

    request_decoder u_request_decoder
    (
        .clk          ( clk          ),
        .reset_i      ( reset_i      ),
        .data_req_i   ( data_req_i   ),
        .data_op_i    ( data_op_i    ),
        .data_add_i   ( data_add_i   ),
        .data_be_i    ( data_be_i    ),
        .data_wdata_i ( data_wdata_i ),
        .bank_req_o   ( bank_req     ),
        .bank_op_o    ( bank_op      ),
        .bank_row_o   ( bank_row     ),
        .bank_be_o    ( bank_be      ),
        .bank_wdata_o ( bank_wdata   )
    );

    //////////////////////
    // Bank stage
    //////////////////////

    // Payload is broadcast, the one-hot strobe selects the bank
    for (genvar k = 0; k < N_BANK; k++)
    begin : gen_bank
        memory_bank u_bank
        (
            .clk       ( clk             ),
            .reset_i   ( reset_i         ),
            .req_i     ( bank_req[k]     ),
            .op_i      ( bank_op         ),
            .row_i     ( bank_row        ),
            .be_i      ( bank_be         ),
            .wdata_i   ( bank_wdata      ),
            .r_valid_o ( bank_r_valid[k] ),
            .r_rdata_o ( bank_r_rdata[k] )
        );
    end

    //////////////////////
    // Response stage
    //////////////////////

    response_tree u_response_tree
    (
        .clk            ( clk            ),
        .reset_i        ( reset_i        ),
        .data_r_valid_i ( bank_r_valid   ),
        .data_r_rdata_i ( bank_r_rdata   ),
        .data_r_valid_o ( data_r_valid_o ),
        .data_r_rdata_o ( data_r_rdata_o )
    );

endmodule

// ==== response_tree.sv ====
module response_tree
(
    input  logic                                   clk,
    input  logic                                   reset_i,

    // One response channel per bank
    input  logic [log_icn_pkg::N_BANK-1:0]         data_r_valid_i,
    input  logic [log_icn_pkg::N_BANK-1:0][log_icn_pkg::DATA_WIDTH-1:0] data_r_rdata_i,

    // Registered master response
    output logic                                   data_r_valid_o,
    output logic [log_icn_pkg::DATA_WIDTH-1:0]     data_r_rdata_o
);

    import log_icn_pkg::*;

    // Heap-ordered node storage
    // Node 0 is the root
    // Node i has children 2i+1 and 2i+2
    // Nodes N_BANK-1 and up are the leaves, one per bank
    logic [2*N_BANK-2:0]                   node_valid;
    logic [2*N_BANK-2:0][DATA_WIDTH-1:0]   node_rdata;

    //////////////////////
    // Leaf level
    //////////////////////

    // Bank responses enter at the bottom of the tree
    for (genvar k = 0; k < N_BANK; k++)
    begin : gen_leaf
        assign node_valid[N_BANK-1+k] = data_r_valid_i[k];
        assign node_rdata[N_BANK-1+k] = data_r_rdata_i[k];
    end

    //////////////////////
    // Fan-in nodes
    //////////////////////

    // Level j holds 2**j nodes, level 0 is the root
    // No arbitration, banks never answer in the same cycle
    for (genvar j = 0; j < LOG_BANK; j++)
    begin : gen_level
        for (genvar k = 0; k < 2**j; k++)
        begin : gen_node
            // Node index and its left child on level j+1
            localparam int NODE  = (2**j - 1) + k;
            localparam int CHILD = (2**(j+1) - 1) + 2*k;

            // Any child valid makes the node valid
            assign node_valid[NODE] = node_valid[CHILD] | node_valid[CHILD+1];

            // Pick the valid child, left one by default
            assign node_rdata[NODE] = node_valid[CHILD+1] ? node_rdata[CHILD+1]
                                                          : node_rdata[CHILD];
        end
    end

    //////////////////////
    // Output register
    //////////////////////

    // Data forced to zero on idle cycles
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            data_r_valid_o <= 1'b0;
            data_r_rdata_o <= '0;
        end
        else
        begin
            data_r_valid_o <= node_valid[0];
            if (node_valid[0])
            begin
                data_r_rdata_o <= node_rdata[0];
            end
            else
            begin
                data_r_rdata_o <= '0;
            end
        end
    end

endmodule

// ==== memory_bank.sv ====
module memory_bank
(
    input  logic                                   clk,
    input  logic                                   reset_i,

    // Request from the request stage
    input  logic                                   req_i,
    input  log_icn_pkg::mem_op_e                   op_i,
    input  logic [log_icn_pkg::ROW_WIDTH-1:0]      row_i,
    input  logic [log_icn_pkg::BE_WIDTH-1:0]       be_i,
    input  logic [log_icn_pkg::DATA_WIDTH-1:0]     wdata_i,

    // Response towards the response tree
    output logic                                   r_valid_o,
    output logic [log_icn_pkg::DATA_WIDTH-1:0]     r_rdata_o
);

    import log_icn_pkg::*;

    // Single-port word array
    logic [DATA_WIDTH-1:0] mem [BANK_DEPTH];

    // Write access to this bank
    logic wr_en;

    assign wr_en = req_i && (op_i == OP_WRITE);

    //////////////////////
    // Storage array
    //////////////////////

    // Byte-enabled write
    // Disabled bytes keep their old contents
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            for (int b = 0; b < BE_WIDTH; b++)
            begin
                if (be_i[b])
                begin
                    mem[row_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    //////////////////////
    // Response
    //////////////////////

    // One-cycle strobe for reads and writes alike
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            r_valid_o <= 1'b0;
        end
        else
        begin
            r_valid_o <= req_i;
        end
    end

    // Read word, or zero as write acknowledge
    // Only meaningful while r_valid_o is high
    always_ff @(posedge clk)
    begin
        if (req_i)
        begin
            if (op_i == OP_WRITE)
            begin
                r_rdata_o <= '0;
            end
            else
            begin
                r_rdata_o <= mem[row_i];
            end
        end
    end

endmodule

// ==== request_decoder.sv ====
module request_decoder
(
    input  logic                                   clk,
    input  logic                                   reset_i,

    // Master request
    input  logic                                   data_req_i,
    input  log_icn_pkg::mem_op_e                   data_op_i,
    input  logic [log_icn_pkg::ADDR_WIDTH-1:0]     data_add_i,
    input  logic [log_icn_pkg::BE_WIDTH-1:0]       data_be_i,
    input  logic [log_icn_pkg::DATA_WIDTH-1:0]     data_wdata_i,

    // Registered bank request, shared payload for all banks
    output logic [log_icn_pkg::N_BANK-1:0]         bank_req_o,
    output log_icn_pkg::mem_op_e                   bank_op_o,
    output logic [log_icn_pkg::ROW_WIDTH-1:0]      bank_row_o,
    output logic [log_icn_pkg::BE_WIDTH-1:0]       bank_be_o,
    output logic [log_icn_pkg::DATA_WIDTH-1:0]     bank_wdata_o
);

    import log_icn_pkg::*;

    // Bank index from the low address bits
    logic [LOG_BANK-1:0]    bank_sel;
    // Row index from the remaining upper bits
    logic [ROW_WIDTH-1:0]   row_sel;
    // One-hot request before the register
    logic [N_BANK-1:0]      bank_onehot;

    //////////////////////
    // Address decode
    //////////////////////

    // Word interleaving
    // Consecutive words land in consecutive banks
    assign bank_sel = data_add_i[LOG_BANK-1:0];
    assign row_sel  = data_add_i[ADDR_WIDTH-1:LOG_BANK];

    always_comb
    begin
        bank_onehot           = '0;
        // All zero when no request arrives
        bank_onehot[bank_sel] = data_req_i;
    end

    //////////////////////
    // Request register
    //////////////////////

    // Strobe register, at most one bit set per cycle
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            bank_req_o <= '0;
        end
        else
        begin
            bank_req_o <= bank_onehot;
        end
    end

    // Payload register
    // Holds its last value between requests
    always_ff @(posedge clk)
    begin
        if (data_req_i)
        begin
            bank_op_o    <= data_op_i;
            bank_row_o   <= row_sel;
            bank_be_o    <= data_be_i;
            bank_wdata_o <= data_wdata_i;
        end
    end

endmodule

// ==== log_icn_pkg.sv ====
package log_icn_pkg;

    //////////////////////
    // Subsystem sizes
    //////////////////////

    // Number of word-interleaved banks, power of two only
    localparam int N_BANK       = 4;
    // Bank select bits taken from the low address bits
    localparam int LOG_BANK     = $clog2(N_BANK);

    // Data word and its byte enables
    localparam int DATA_WIDTH   = 32;
    localparam int BE_WIDTH     = DATA_WIDTH / 8;

    // Word address from the master
    localparam int ADDR_WIDTH   = 8;
    // Row address inside one bank
    localparam int ROW_WIDTH    = ADDR_WIDTH - LOG_BANK;
    // Words held by each bank
    localparam int BANK_DEPTH   = 2 ** ROW_WIDTH;

    // Request sample to response strobe
    // One cycle each for request, bank and response stage
    localparam int RESP_LATENCY = 3;

    //////////////////////
    // Memory opcodes
    //////////////////////

    // Single bit on the bus
    typedef enum logic [0:0]
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

endpackage
